// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mcast_xbar
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
mcast_xbar_pkg.sv
xbar_link_if.sv
mcast_addr_decode.sv
mcast_demux.sv
mcast_mux.sv
mcast_xbar.sv
tb_mcast_xbar_sva.sv
tb_mcast_xbar.sv

// File: tb_mcast_xbar.sv
// Directed testbench for the multicast crossbar, run through the file list with the Makefile
`timescale 1ns/1ns

module tb_mcast_xbar
  import mcast_xbar_pkg::*;
();

  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned NUM_TESTS   = 5;
  localparam int unsigned RAND_WRITES = 12;
  localparam logic [31:0] LFSR_SEED   = 32'h7238_bfa7;

  logic                 clk_i            = 1'b0;
  logic                 reset_i          = 1'b1;
  logic [NUM_INIT-1:0]  init_req_valid_i = '0;
  logic [NUM_INIT-1:0]  init_req_ready_o;
  req_t [NUM_INIT-1:0]  init_req_i       = '0;
  logic [NUM_INIT-1:0]  init_rsp_valid_o;
  logic [NUM_INIT-1:0]  init_rsp_ready_i = '1;
  resp_t [NUM_INIT-1:0] init_rsp_o;
  logic [NUM_TGT-1:0]   tgt_req_valid_o;
  logic [NUM_TGT-1:0]   tgt_req_ready_i  = '0;
  addr_t [NUM_TGT-1:0]  tgt_req_addr_o;
  data_t [NUM_TGT-1:0]  tgt_req_data_o;
  logic [NUM_TGT-1:0]   tgt_rsp_valid_i  = '0;
  logic [NUM_TGT-1:0]   tgt_rsp_ready_o;
  resp_t [NUM_TGT-1:0]  tgt_rsp_i        = {NUM_TGT{RESP_OKAY}};

  logic [31:0] lfsr_q     = LFSR_SEED;
  int          resp_errs  = 0;
  int          req_errs   = 0;
  int          stat_errs  = 0;
  int          other_errs = 0;

  // Writes still to issue, and what each initiator and target should see
  req_t  stim [NUM_INIT][$];
  resp_t exp_rsp [NUM_INIT][$];
  addr_t exp_addr [NUM_INIT][NUM_TGT][$];
  data_t exp_data [NUM_INIT][NUM_TGT][$];
  // Requests seen by the target models
  addr_t log_addr [NUM_TGT][$];
  data_t log_data [NUM_TGT][$];

  logic [NUM_TGT-1:0] tgt_busy = '0;
  int                 tgt_delay [NUM_TGT];
  resp_t              tgt_code [NUM_TGT];

  mcast_xbar #(
    .NUM_INIT ( NUM_INIT ),
    .NUM_TGT  ( NUM_TGT  )
  ) mcast_xbar_i (
    .*
  );

  bind mcast_xbar tb_mcast_xbar_sva #(
    .NUM_INIT ( NUM_INIT ),
    .NUM_TGT  ( NUM_TGT  )
  ) sva_i (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .init_req_ready_o ( init_req_ready_o ),
    .init_rsp_valid_o ( init_rsp_valid_o ),
    .init_rsp_ready_i ( init_rsp_ready_i ),
    .init_rsp_o       ( init_rsp_o       ),
    .tgt_req_valid_o  ( tgt_req_valid_o  ),
    .tgt_req_ready_i  ( tgt_req_ready_i  ),
    .tgt_req_addr_o   ( tgt_req_addr_o   ),
    .tgt_req_data_o   ( tgt_req_data_o   )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Galois LFSR, one step per bit taken
  function automatic logic [7:0] rand_bits(input int unsigned n);
    logic [7:0] val;
    val = '0;
    for (int unsigned b = 0; b < n; b++) begin
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
      val    = {val[6:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Target models accept after a random wait and answer after a random delay
  always @(posedge clk_i) begin
    if (reset_i) begin
      tgt_req_ready_i <= '0;
      tgt_rsp_valid_i <= '0;
      tgt_busy        <= '0;
    end else begin
      for (int j = 0; j < NUM_TGT; j++) begin
        if (tgt_rsp_valid_i[j]) begin
          if (tgt_rsp_ready_o[j]) begin
            tgt_rsp_valid_i[j] <= 1'b0;
          end
        end else if (tgt_busy[j]) begin
          if (tgt_delay[j] == 0) begin
            tgt_rsp_valid_i[j] <= 1'b1;
            tgt_rsp_i[j]       <= tgt_code[j];
            tgt_busy[j]        <= 1'b0;
          end else begin
            tgt_delay[j] <= tgt_delay[j] - 1;
          end
        end else if (tgt_req_valid_o[j] && tgt_req_ready_i[j]) begin
          log_addr[j].push_back(tgt_req_addr_o[j]);
          log_data[j].push_back(tgt_req_data_o[j]);
          // All ones in offset bits 11 to 2 marks a faulty register
          tgt_code[j]        <= (&tgt_req_addr_o[j][11:2]) ? RESP_SLVERR : RESP_OKAY;
          tgt_delay[j]       <= int'(rand_bits(2));
          tgt_busy[j]        <= 1'b1;
          tgt_req_ready_i[j] <= 1'b0;
        end else begin
          tgt_req_ready_i[j] <= (rand_bits(2) != 8'd0);
        end
      end
    end
  end

  function automatic req_t make_req(input int idx, input int idx_mask, input int ofs,
                                    input data_t data);
    req_t r;
    r.addr = MAP_TAG | (addr_t'(TGT_IDX_W'(idx)) << TGT_OFS_W) | addr_t'(TGT_OFS_W'(ofs));
    r.mask = addr_t'(TGT_IDX_W'(idx_mask)) << TGT_OFS_W;
    r.data = data;
    return r;
  endfunction

  // Unmapped when a tag bit is masked or differs from the map
  function automatic logic expect_decerr(input req_t r);
    logic err;
    err = 1'b0;
    for (int b = TAG_LSB; b < ADDR_W; b++) begin
      if (r.mask[b] || (r.addr[b] != MAP_TAG[b])) begin
        err = 1'b1;
      end
    end
    return err;
  endfunction

  function automatic logic expect_target(input req_t r, input int j);
    logic [TGT_IDX_W-1:0] jv;
    logic                 hit;
    jv  = TGT_IDX_W'(j);
    hit = !expect_decerr(r);
    for (int b = 0; b < TGT_IDX_W; b++) begin
      if (!r.mask[TGT_OFS_W + b] && (r.addr[TGT_OFS_W + b] != jv[b])) begin
        hit = 1'b0;
      end
    end
    return hit;
  endfunction

  task automatic record_expected(input int i, input req_t r);
    addr_t a;
    for (int j = 0; j < NUM_TGT; j++) begin
      if (expect_target(r, j)) begin
        a = r.addr;
        a[TGT_OFS_W +: TGT_IDX_W] = TGT_IDX_W'(j);
        exp_addr[i][j].push_back(a);
        exp_data[i][j].push_back(r.data);
      end
    end
    if (expect_decerr(r)) begin
      exp_rsp[i].push_back(RESP_DECERR);
    end else begin
      exp_rsp[i].push_back((&r.addr[11:2]) ? RESP_SLVERR : RESP_OKAY);
    end
  endtask

  task automatic check_resp(input resp_t got, input resp_t want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s is %s, expected %s",
               $time, what, got.name(), want.name());
      resp_errs++;
    end
  endtask

  task automatic check_tgt_req(input addr_t got_addr, input data_t got_data,
                               input addr_t want_addr, input data_t want_data, input string what);
    if (got_addr !== want_addr || got_data !== want_data) begin
      $display("CHECK FAILED at %0t ns: %s has address %h data %h, expected %h %h",
               $time, what, got_addr, got_data, want_addr, want_data);
      req_errs++;
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
      stat_errs++;
    end
  endtask

  // Plays the queued writes on all initiators and checks each response
  task automatic run_traffic(input logic rand_bp);
    logic [NUM_INIT-1:0] active;
    req_t                r;
    int                  left;
    active = '0;
    do begin
      @(posedge clk_i);
      left = 0;
      for (int i = 0; i < NUM_INIT; i++) begin
        if (init_rsp_valid_o[i] && init_rsp_ready_i[i]) begin
          if (exp_rsp[i].size() == 0) begin
            $display("ERROR: initiator %0d got a response with no write outstanding", i);
            other_errs++;
          end else begin
            check_resp(init_rsp_o[i], exp_rsp[i].pop_front(), "initiator response");
          end
          active[i] = 1'b0;
        end
        if (init_req_valid_i[i] && init_req_ready_o[i]) begin
          init_req_valid_i[i] <= 1'b0;
        end else if (!active[i] && stim[i].size() > 0) begin
          r = stim[i].pop_front();
          record_expected(i, r);
          init_req_i[i]       <= r;
          init_req_valid_i[i] <= 1'b1;
          active[i] = 1'b1;
        end
        left += stim[i].size();
      end
      init_rsp_ready_i <= rand_bp ? NUM_INIT'(rand_bits(NUM_INIT)) : '1;
    end while (left != 0 || active != '0);
  endtask

  // Top data byte names the initiator, each target must see its writes in order
  task automatic check_delivery();
    addr_t a;
    data_t d;
    int    src;
    for (int j = 0; j < NUM_TGT; j++) begin
      while (log_addr[j].size() > 0) begin
        a   = log_addr[j].pop_front();
        d   = log_data[j].pop_front();
        src = int'(d[31:24]);
        if (src >= NUM_INIT || exp_addr[src][j].size() == 0) begin
          $display("ERROR: target %0d received an unexpected write to %h", j, a);
          other_errs++;
        end else begin
          check_tgt_req(a, d, exp_addr[src][j].pop_front(), exp_data[src][j].pop_front(),
                        "target request");
        end
      end
      for (int i = 0; i < NUM_INIT; i++) begin
        if (exp_addr[i][j].size() != 0) begin
          $display("ERROR: target %0d missed %0d write(s) from initiator %0d",
                   j, exp_addr[i][j].size(), i);
          other_errs++;
          exp_addr[i][j].delete();
          exp_data[i][j].delete();
        end
      end
    end
  endtask

  task automatic test_reset();
    @(posedge clk_i);
    check_status(32'(tgt_req_valid_o), 32'd0, "target request valid after reset");
    check_status(32'(init_rsp_valid_o), 32'd0, "initiator response valid after reset");
    check_status(32'(init_req_ready_o), 32'((1 << NUM_INIT) - 1), "initiator ready after reset");
  endtask

  task automatic test_unicast();
    for (int j = 0; j < NUM_TGT; j++) begin
      stim[j % NUM_INIT].push_back(make_req(j, 0, 16 * j + 4, {8'(j % NUM_INIT), 8'h5A, 16'(j)}));
    end
    run_traffic(1'b0);
    check_delivery();
  endtask

  task automatic test_multicast();
    stim[0].push_back(make_req(1, 3, 'h040, {8'd0, 24'h00_C0DE}));
    stim[1].push_back(make_req(2, 1, 'hFFC, {8'd1, 24'h00_BEEF}));
    stim[0].push_back(make_req(0, 2, 'hFFF, {8'd0, 24'h00_F00D}));
    run_traffic(1'b0);
    check_delivery();
  endtask

  task automatic test_decode_error();
    req_t r;
    r = make_req(0, 0, 'h100, {8'd0, 24'h00_DEAD});
    r.addr = 32'h2000_0100;
    stim[0].push_back(r);
    // Correct tag, but a mask bit reaches into it
    r = make_req(3, 0, 'h020, {8'd1, 24'h00_0BAD});
    r.mask[TAG_LSB + 2] = 1'b1;
    stim[1].push_back(r);
    run_traffic(1'b0);
    check_delivery();
  endtask

  task automatic test_contention();
    int ofs;
    for (int n = 0; n < RAND_WRITES; n++) begin
      for (int i = 0; i < NUM_INIT; i++) begin
        ofs = (rand_bits(2) == 8'd0) ? 'hFFC : int'(rand_bits(8)) * 4;
        stim[i].push_back(make_req(int'(rand_bits(TGT_IDX_W)), int'(rand_bits(TGT_IDX_W)), ofs,
                                   {8'(i), 8'(n), rand_bits(8), rand_bits(8)}));
      end
    end
    run_traffic(1'b1);
    check_delivery();
  endtask

  initial begin
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    test_reset();
    test_unicast();
    test_multicast();
    test_decode_error();
    test_contention();
    repeat (4) @(posedge clk_i);
    $display("Errors: response %0d, target request %0d, status %0d, other %0d",
             resp_errs, req_errs, stat_errs, other_errs);
    if (resp_errs + req_errs + stat_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // 200 cycles allowed per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("ERROR: run did not finish within %0d cycles", NUM_TESTS * 200);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb_mcast_xbar_sva.sv
// Concurrent assertions on crossbar handshake stability and reset state, bound in by the testbench
`timescale 1ns/1ns

module tb_mcast_xbar_sva
  import mcast_xbar_pkg::*;
#(
  parameter int unsigned NUM_INIT = mcast_xbar_pkg::NUM_INIT,
  parameter int unsigned NUM_TGT  = mcast_xbar_pkg::NUM_TGT
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic [NUM_INIT-1:0]   init_req_ready_o,
  input logic [NUM_INIT-1:0]   init_rsp_valid_o,
  input logic [NUM_INIT-1:0]   init_rsp_ready_i,
  input resp_t [NUM_INIT-1:0]  init_rsp_o,
  input logic [NUM_TGT-1:0]    tgt_req_valid_o,
  input logic [NUM_TGT-1:0]    tgt_req_ready_i,
  input addr_t [NUM_TGT-1:0]   tgt_req_addr_o,
  input data_t [NUM_TGT-1:0]   tgt_req_data_o
);

  // Idle outputs in the cycle after a reset edge
  assert property (@(posedge clk_i) reset_i |=>
      (init_rsp_valid_o == '0) && (tgt_req_valid_o == '0) && (&init_req_ready_o))
    else $error("crossbar outputs are not idle after reset");

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt
    assert property (@(posedge clk_i) disable iff (reset_i)
        tgt_req_valid_o[j] && !tgt_req_ready_i[j] |=> tgt_req_valid_o[j] &&
        $stable(tgt_req_addr_o[j]) && $stable(tgt_req_data_o[j]))
      else $error("target %0d request changed before it was accepted", j);
  end

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    assert property (@(posedge clk_i) disable iff (reset_i)
        init_rsp_valid_o[i] && !init_rsp_ready_i[i] |=>
        init_rsp_valid_o[i] && $stable(init_rsp_o[i]))
      else $error("initiator %0d response changed before it was taken", i);
  end

endmodule

// File: mcast_xbar.sv
// Top level of the multicast write crossbar, one demux per initiator and one mux per target
`timescale 1ns/1ns

module mcast_xbar
  import mcast_xbar_pkg::*;
#(
  parameter int unsigned NUM_INIT = mcast_xbar_pkg::NUM_INIT,
  parameter int unsigned NUM_TGT  = mcast_xbar_pkg::NUM_TGT
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [NUM_INIT-1:0]   init_req_valid_i,
  output logic [NUM_INIT-1:0]   init_req_ready_o,
  input  req_t [NUM_INIT-1:0]   init_req_i,
  output logic [NUM_INIT-1:0]   init_rsp_valid_o,
  input  logic [NUM_INIT-1:0]   init_rsp_ready_i,
  output resp_t [NUM_INIT-1:0]  init_rsp_o,
  output logic [NUM_TGT-1:0]    tgt_req_valid_o,
  input  logic [NUM_TGT-1:0]    tgt_req_ready_i,
  output addr_t [NUM_TGT-1:0]   tgt_req_addr_o,
  output data_t [NUM_TGT-1:0]   tgt_req_data_o,
  input  logic [NUM_TGT-1:0]    tgt_rsp_valid_i,
  output logic [NUM_TGT-1:0]    tgt_rsp_ready_o,
  input  resp_t [NUM_TGT-1:0]   tgt_rsp_i
);

  // Link mesh, indexed by initiator then target
  logic  [NUM_INIT-1:0][NUM_TGT-1:0] mesh_req_valid;
  logic  [NUM_INIT-1:0][NUM_TGT-1:0] mesh_req_ready;
  req_t  [NUM_INIT-1:0][NUM_TGT-1:0] mesh_req;
  logic  [NUM_INIT-1:0][NUM_TGT-1:0] mesh_rsp_valid;
  logic  [NUM_INIT-1:0][NUM_TGT-1:0] mesh_rsp_ready;
  resp_t [NUM_INIT-1:0][NUM_TGT-1:0] mesh_rsp;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_init
    xbar_link_if init_links [NUM_TGT] ();

    mcast_demux #(
      .NUM_TGT ( NUM_TGT )
    ) i_demux (
      .clk_i,
      .reset_i,
      .req_valid_i ( init_req_valid_i[i] ),
      .req_ready_o ( init_req_ready_o[i] ),
      .req_i       ( init_req_i[i]       ),
      .rsp_valid_o ( init_rsp_valid_o[i] ),
      .rsp_ready_i ( init_rsp_ready_i[i] ),
      .rsp_o       ( init_rsp_o[i]       ),
      .links       ( init_links          )
    );

    for (genvar j = 0; j < NUM_TGT; j++) begin : gen_cross
      assign mesh_req_valid[i][j]    = init_links[j].req_valid;
      assign mesh_req[i][j]          = init_links[j].req;
      assign mesh_rsp_ready[i][j]    = init_links[j].rsp_ready;
      assign init_links[j].req_ready = mesh_req_ready[i][j];
      assign init_links[j].rsp_valid = mesh_rsp_valid[i][j];
      assign init_links[j].rsp       = mesh_rsp[i][j];
    end
  end

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_tgt
    xbar_link_if tgt_links [NUM_INIT] ();

    mcast_mux #(
      .NUM_INIT ( NUM_INIT )
    ) i_mux (
      .clk_i,
      .reset_i,
      .links           ( tgt_links          ),
      .tgt_req_valid_o ( tgt_req_valid_o[j] ),
      .tgt_req_ready_i ( tgt_req_ready_i[j] ),
      .tgt_req_addr_o  ( tgt_req_addr_o[j]  ),
      .tgt_req_data_o  ( tgt_req_data_o[j]  ),
      .tgt_rsp_valid_i ( tgt_rsp_valid_i[j] ),
      .tgt_rsp_ready_o ( tgt_rsp_ready_o[j] ),
      .tgt_rsp_i       ( tgt_rsp_i[j]       )
    );

    for (genvar i = 0; i < NUM_INIT; i++) begin : gen_cross
      assign tgt_links[i].req_valid = mesh_req_valid[i][j];
      assign tgt_links[i].req       = mesh_req[i][j];
      assign tgt_links[i].rsp_ready = mesh_rsp_ready[i][j];
      assign mesh_req_ready[i][j]   = tgt_links[i].req_ready;
      assign mesh_rsp_valid[i][j]   = tgt_links[i].rsp_valid;
      assign mesh_rsp[i][j]         = tgt_links[i].rsp;
    end
  end

endmodule

// File: mcast_mux.sv
// Per-target round-robin arbiter that forwards one link's request and routes the response back
`timescale 1ns/1ns

module mcast_mux
  import mcast_xbar_pkg::*;
#(
  parameter int unsigned NUM_INIT = mcast_xbar_pkg::NUM_INIT
) (
  input  logic        clk_i,
  input  logic        reset_i,
  xbar_link_if.target links [NUM_INIT],
  output logic        tgt_req_valid_o,
  input  logic        tgt_req_ready_i,
  output addr_t       tgt_req_addr_o,
  output data_t       tgt_req_data_o,
  input  logic        tgt_rsp_valid_i,
  output logic        tgt_rsp_ready_o,
  input  resp_t       tgt_rsp_i
);

  localparam int unsigned IDX_W = (NUM_INIT > 1) ? $clog2(NUM_INIT) : 1;

  logic [NUM_INIT-1:0]  link_req_valid;
  logic [NUM_INIT-1:0]  link_rsp_ready;
  req_t [NUM_INIT-1:0]  link_req;

  // Highest priority link, moved past the winner on completion
  logic [IDX_W-1:0]     rr_ptr;
  logic [IDX_W-1:0]     rr_gnt;
  logic [IDX_W-1:0]     gnt;
  logic [IDX_W-1:0]     gnt_q;
  // Lock spans request to response, hold keeps an offered request stable
  logic                 lock_q;
  logic                 hold_q;
  logic                 req_hs;
  logic                 rsp_hs;

  for (genvar i = 0; i < NUM_INIT; i++) begin : gen_link
    assign link_req_valid[i] = links[i].req_valid;
    assign link_req[i]       = links[i].req;
    assign link_rsp_ready[i] = links[i].rsp_ready;

    assign links[i].req_ready = ~lock_q & (gnt == IDX_W'(i)) & tgt_req_ready_i;
    assign links[i].rsp_valid = lock_q & (gnt_q == IDX_W'(i)) & tgt_rsp_valid_i;
    assign links[i].rsp       = tgt_rsp_i;
  end

  // First requesting link at or after the pointer
  always_comb begin
    int unsigned cand;
    logic        found;
    rr_gnt = rr_ptr;
    found  = 1'b0;
    for (int unsigned k = 0; k < NUM_INIT; k++) begin
      cand = (int'(rr_ptr) + k) % NUM_INIT;
      if (!found && link_req_valid[cand]) begin
        rr_gnt = IDX_W'(cand);
        found  = 1'b1;
      end
    end
  end

  assign gnt = (lock_q | hold_q) ? gnt_q : rr_gnt;

  assign tgt_req_valid_o = ~lock_q & link_req_valid[gnt];
  assign tgt_req_addr_o  = link_req[gnt].addr;
  assign tgt_req_data_o  = link_req[gnt].data;
  assign tgt_rsp_ready_o = lock_q & link_rsp_ready[gnt_q];

  assign req_hs = tgt_req_valid_o & tgt_req_ready_i;
  assign rsp_hs = tgt_rsp_valid_i & tgt_rsp_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
      hold_q <= 1'b0;
    end else if (!lock_q) begin
      gnt_q  <= gnt;
      hold_q <= tgt_req_valid_o & ~tgt_req_ready_i;
      if (req_hs) begin
        lock_q <= 1'b1;
      end
    end else if (rsp_hs) begin
      lock_q <= 1'b0;
      rr_ptr <= (gnt_q == IDX_W'(NUM_INIT - 1)) ? '0 : gnt_q + 1'b1;
    end
  end

endmodule

// File: mcast_demux.sv
// Per-initiator fork of one write to its selected targets and join of their responses
`timescale 1ns/1ns

module mcast_demux
  import mcast_xbar_pkg::*;
#(
  parameter int unsigned NUM_TGT = mcast_xbar_pkg::NUM_TGT
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  req_t                  req_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output resp_t                 rsp_o,
  xbar_link_if.initiator        links [NUM_TGT]
);

  tgt_sel_t              sel;
  logic                  dec_err;
  logic                  req_hs;
  logic                  last_rsp;

  // Registered request and the merged response so far
  req_t                  req_q;
  resp_t                 rsp_q;
  resp_t                 merged;
  logic                  rsp_valid_q;

  // Links still waiting for request acceptance, and for a response
  logic [NUM_TGT-1:0]    pend_req;
  logic [NUM_TGT-1:0]    pend_rsp;

  logic [NUM_TGT-1:0]    link_req_ready;
  logic [NUM_TGT-1:0]    link_rsp_valid;
  logic [NUM_TGT-1:0]    rsp_hs;
  resp_t [NUM_TGT-1:0]   link_rsp;

  mcast_addr_decode i_decode (
    .req_i     ( req_i   ),
    .sel_o     ( sel     ),
    .dec_err_o ( dec_err )
  );

  // Busy from acceptance until the initiator takes the response
  assign req_ready_o = ~(|pend_rsp) & ~rsp_valid_q;
  assign req_hs      = req_valid_i & req_ready_o;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  for (genvar j = 0; j < NUM_TGT; j++) begin : gen_link
    req_t fwd;

    // Each copy is a unicast to target j
    always_comb begin
      fwd = req_q;
      fwd.addr[TGT_OFS_W +: TGT_IDX_W] = TGT_IDX_W'(j);
      fwd.mask = '0;
    end

    assign links[j].req_valid = pend_req[j];
    assign links[j].req       = fwd;
    assign links[j].rsp_ready = pend_rsp[j];

    assign link_req_ready[j] = links[j].req_ready;
    assign link_rsp_valid[j] = links[j].rsp_valid;
    assign link_rsp[j]       = links[j].rsp;
  end

  assign rsp_hs   = link_rsp_valid & pend_rsp;
  assign last_rsp = (|pend_rsp) & ((pend_rsp & ~rsp_hs) == '0);

  // Join all responses arriving in this cycle
  always_comb begin
    merged = rsp_q;
    for (int unsigned j = 0; j < NUM_TGT; j++) begin
      if (rsp_hs[j]) begin
        merged = resp_merge(merged, link_rsp[j]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_req    <= '0;
      pend_rsp    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      pend_req <= pend_req & ~link_req_ready;
      pend_rsp <= pend_rsp & ~rsp_hs;
      if (req_hs) begin
        if (dec_err) begin
          // Unmapped address, answered here without any link traffic
          rsp_valid_q <= 1'b1;
        end else begin
          pend_req <= sel;
          pend_rsp <= sel;
        end
      end else if (last_rsp) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= req_i;
      rsp_q <= dec_err ? RESP_DECERR : RESP_OKAY;
    end else if (|rsp_hs) begin
      rsp_q <= merged;
    end
  end

endmodule

// File: mcast_addr_decode.sv
// Combinational decode of a request address and multicast mask into a target set and error flag
`timescale 1ns/1ns

module mcast_addr_decode
  import mcast_xbar_pkg::*;
(
  input  req_t     req_i,
  output tgt_sel_t sel_o,
  output logic     dec_err_o
);

  logic [TGT_IDX_W-1:0] idx;
  logic [TGT_IDX_W-1:0] idx_mask;
  logic                 tag_miss;
  logic                 tag_masked;

  // Target index field and its don't-care bits
  assign idx      = req_i.addr[TGT_OFS_W +: TGT_IDX_W];
  assign idx_mask = req_i.mask[TGT_OFS_W +: TGT_IDX_W];

  // An unmasked tag bit that differs from the map
  assign tag_miss   = |((req_i.addr ^ MAP_TAG) & ~req_i.mask & TAG_MASK);
  // Multicast over the tag would leave the map
  assign tag_masked = |(req_i.mask & TAG_MASK);

  assign dec_err_o = tag_miss | tag_masked;

  // Target j matches when it agrees with the index in every cared-for bit
  always_comb begin
    sel_o = '0;
    if (!dec_err_o) begin
      for (int unsigned j = 0; j < NUM_TGT; j++) begin
        sel_o[j] = (((TGT_IDX_W'(j) ^ idx) & ~idx_mask) == '0);
      end
    end
  end

endmodule

// File: xbar_link_if.sv
// One initiator-to-target link of the crossbar mesh, used through its initiator and target modports
`timescale 1ns/1ns

interface xbar_link_if
  import mcast_xbar_pkg::*;
();

  // Request channel, demux towards mux
  logic  req_valid;
  logic  req_ready;
  req_t  req;

  // Response channel, mux back towards demux
  logic  rsp_valid;
  logic  rsp_ready;
  resp_t rsp;

  // Demux side
  modport initiator (
    output req_valid, req, rsp_ready,
    input  req_ready, rsp_valid, rsp
  );

  // Mux side
  modport target (
    input  req_valid, req, rsp_ready,
    output req_ready, rsp_valid, rsp
  );

endinterface

// File: mcast_xbar_pkg.sv
// Widths, fixed address map, request and response types shared by the crossbar RTL and testbench
package mcast_xbar_pkg;

  // Port counts, overridden through the top-level parameters
  localparam int unsigned NUM_INIT = 2;
  localparam int unsigned NUM_TGT  = 4;

  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned TGT_OFS_W = 12;
  localparam int unsigned TGT_IDX_W = $clog2(NUM_TGT);
  // Lowest address bit of the tag field above the target index
  localparam int unsigned TAG_LSB   = TGT_OFS_W + TGT_IDX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Tag value kept in place, the map starts at 0x1000_0000
  localparam addr_t MAP_TAG  = addr_t'(32'h1000_0) << TGT_OFS_W;
  // Selects the address bits that belong to the tag
  localparam addr_t TAG_MASK = ~((addr_t'(1) << TAG_LSB) - addr_t'(1));

  // A set mask bit makes the matching address bit a don't-care
  typedef struct packed {
    addr_t addr;
    data_t data;
    addr_t mask;
  } req_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_t;

  typedef logic [NUM_TGT-1:0] tgt_sel_t;

  // Multicast join keeps the worst code, which is the largest one
  function automatic resp_t resp_merge(resp_t a, resp_t b);
    return (a > b) ? a : b;
  endfunction

endpackage
